//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
  parameter  int NUM_LINES  = 128,
  localparam int IDX_W      = $clog2(NUM_LINES),
  localparam int TAG_W      = ADDR_W - IDX_W - OFFSET_W,
  localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE)
) (
  input  logic                  clk,
  input  logic                  rst,
  // cpu side
  input  logic                  req_valid_i,
  input  cpu_req_t              req_i,
  output logic                  done_o,        // one cycle pulse
  output logic [WORD_W-1:0]     rdata_o,
  // memory read port
  output logic                  rd_valid_o,
  output mem_rd_req_t           rd_req_o,
  input  logic                  rd_beat_i,
  input  logic [WORD_W-1:0]     rd_data_i,
  // memory write port
  output logic                  wr_valid_o,
  output mem_wr_req_t           wr_req_o,
  output logic [WORD_W-1:0]     wr_data_o,
  input  logic                  wr_beat_i,
  // tag store
  input  logic                  hit_i,
  input  logic                  dirty_i,
  input  logic [TAG_W-1:0]      victim_tag_i,
  output logic                  tag_write_o,
  output logic                  set_dirty_o,
  // data store
  input  logic [WORD_W-1:0]     hit_word_i,    // cpu word of the line
  input  logic [WORD_W-1:0]     line_word_i,   // word at data_word_o
  output logic                  data_wen_o,
  output logic [WORD_IDX_W-1:0] data_word_o,
  output logic [WORD_W-1:0]     data_wdata_o,
  output logic [MASK_W-1:0]     data_wmask_o
);

  localparam logic [WORD_IDX_W-1:0] LAST_BEAT = WORD_IDX_W'(BURST_LEN);

  ctrl_state_e           state_q;
  logic [WORD_IDX_W-1:0] beat_q;       // burst beat counter
  mem_rd_req_t           rd_req_q;
  mem_wr_req_t           wr_req_q;
  logic [WORD_W-1:0]     unc_rdata_q;  // bypass read data, shown in resp

  logic              uncached;
  logic              lookup;
  logic              write_hit;
  logic              rd_fire;
  logic              wr_fire;
  logic              last_beat;
  logic              refill_beat;
  logic [IDX_W-1:0]  index;
  logic [ADDR_W-1:0] line_addr;
  logic [ADDR_W-1:0] victim_addr;

  assign uncached    = req_i.addr[UNCACHED_BIT];
  assign index       = req_i.addr[OFFSET_W +: IDX_W];
  assign line_addr   = {req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign victim_addr = {victim_tag_i, index, {OFFSET_W{1'b0}}};  // old line

  assign lookup      = (state_q == ST_IDLE) && req_valid_i && !uncached;
  assign write_hit   = lookup && hit_i && req_i.write;
  assign rd_fire     = rd_valid_o && rd_beat_i;
  assign wr_fire     = wr_valid_o && wr_beat_i;
  assign last_beat   = (beat_q == LAST_BEAT);
  assign refill_beat = (state_q == ST_REFILL) && rd_fire;

  // state and beat counter
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          beat_q <= '0;
          if (req_valid_i && uncached) begin
            state_q <= req_i.write ? ST_UNC_WRITE : ST_UNC_READ;
          end else if (lookup && hit_i) begin
            state_q <= ST_RESP;  // store already written on this edge
          end else if (lookup && dirty_i) begin
            state_q <= ST_WRITEBACK;  // victim out first
          end else if (lookup) begin
            state_q <= ST_REFILL;
          end
        end
        ST_WRITEBACK: begin
          if (wr_fire) begin
            if (last_beat) begin
              state_q <= ST_REFILL;
              beat_q  <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        ST_REFILL: begin
          if (rd_fire) begin
            if (last_beat) begin
              state_q <= ST_IDLE;  // retry, hits now
              beat_q  <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        ST_UNC_READ, ST_UNC_WRITE: begin
          if (rd_fire || wr_fire) begin
            state_q <= ST_RESP;  // one beat only
          end
        end
        ST_RESP: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // burst requests loaded while idle, held through the transfer
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      rd_req_q.addr <= uncached ? req_i.addr : line_addr;
      rd_req_q.len  <= uncached ? 8'd0 : 8'(BURST_LEN);
      wr_req_q.addr <= uncached ? req_i.addr : victim_addr;
      wr_req_q.mask <= uncached ? req_i.mask : {MASK_W{1'b1}};
      wr_req_q.len  <= uncached ? 8'd0 : 8'(BURST_LEN);
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ST_UNC_READ) && rd_fire) begin
      unc_rdata_q <= rd_data_i;
    end
  end

  // memory side, valids straight from state so never both high
  assign rd_valid_o = (state_q == ST_REFILL) || (state_q == ST_UNC_READ);
  assign wr_valid_o = (state_q == ST_WRITEBACK) || (state_q == ST_UNC_WRITE);
  assign rd_req_o   = rd_req_q;
  assign wr_req_o   = wr_req_q;
  assign wr_data_o  = (state_q == ST_UNC_WRITE) ? req_i.wdata : line_word_i;

  // cpu side
  assign done_o  = (state_q == ST_RESP);
  assign rdata_o = uncached ? unc_rdata_q : hit_word_i;

  // store controls, cpu word when idle, burst word otherwise
  assign tag_write_o  = write_hit || (refill_beat && last_beat);
  assign set_dirty_o  = write_hit;  // refill loads a clean line
  assign data_wen_o   = write_hit || refill_beat;
  assign data_word_o  = (state_q == ST_IDLE) ? req_i.addr[OFFSET_W-1 -: WORD_IDX_W] : beat_q;
  assign data_wdata_o = (state_q == ST_REFILL) ? rd_data_i : req_i.wdata;
  assign data_wmask_o = (state_q == ST_REFILL) ? {MASK_W{1'b1}} : req_i.mask;

endmodule

//--- logic/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store import dcache_pkg::*; #(
  parameter  int NUM_LINES  = 128,
  localparam int IDX_W      = $clog2(NUM_LINES),
  localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE)
) (
  input  logic                  clk,
  input  logic [IDX_W-1:0]      index_i,    // line select, shared by all ports
  input  logic [WORD_IDX_W-1:0] word_i,     // cpu word in the line
  input  logic [WORD_IDX_W-1:0] wr_word_i,  // write / writeback word
  input  logic                  wen_i,
  input  logic [WORD_W-1:0]     wdata_i,
  input  logic [MASK_W-1:0]     wmask_i,    // byte enables
  output logic [WORD_W-1:0]     rdata_o,    // cpu read word
  output logic [WORD_W-1:0]     wb_data_o   // writeback word
);

  localparam int DEPTH  = NUM_LINES * WORDS_PER_LINE;
  localparam int ADDR_B = IDX_W + WORD_IDX_W;

  // flat word array, line index in the upper address bits
  logic [WORD_W-1:0] mem_q [DEPTH];

  logic [ADDR_B-1:0] rd_addr;
  logic [ADDR_B-1:0] wr_addr;

  assign rd_addr = {index_i, word_i};
  assign wr_addr = {index_i, wr_word_i};

  // masked write of one word per clock
  always_ff @(posedge clk) begin
    if (wen_i) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (wmask_i[b]) begin
          mem_q[wr_addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // both reads combinational
  assign rdata_o   = mem_q[rd_addr];
  assign wb_data_o = mem_q[wr_addr];  // follows the burst counter

endmodule

//--- logic/dcache_pkg.sv
package dcache_pkg;

  // cpu side geometry
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int MASK_W         = WORD_W / 8;  // one enable per byte lane
  localparam int WORDS_PER_LINE = 16;
  localparam int OFFSET_W       = 6;           // byte offset in a 64 byte line

  // burst length codes count beats minus one
  localparam int BURST_LEN      = 15;          // full line, 16 beats
  // single word uncached access goes out with length 0

  localparam int UNCACHED_BIT   = 31;          // addr[31] set bypasses the cache

  // cpu load/store request, held stable until done
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic [MASK_W-1:0] mask;   // byte enables, writes only
    logic              write;  // 1 store, 0 load
  } cpu_req_t;

  // memory read request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;   // line aligned for refill
    logic [7:0]        len;    // beats minus one
  } mem_rd_req_t;

  // memory write request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;   // all ones for writeback
    logic [7:0]        len;
  } mem_wr_req_t;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,       // lookup, hit goes straight to resp
    ST_WRITEBACK,  // dirty victim out, 16 beats
    ST_REFILL,     // new line in, 16 beats
    ST_UNC_READ,   // single beat bypass read
    ST_UNC_WRITE,  // single beat bypass write
    ST_RESP        // done pulse
  } ctrl_state_e;

endpackage

//--- logic/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store import dcache_pkg::*; #(
  parameter  int NUM_LINES = 128,
  localparam int IDX_W     = $clog2(NUM_LINES),
  localparam int TAG_W     = ADDR_W - IDX_W - OFFSET_W
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [IDX_W-1:0] index_i,      // line being looked up
  input  logic [TAG_W-1:0] tag_i,        // tag of the cpu address
  input  logic             tag_write_i,  // refill done or write hit
  input  logic             set_dirty_i,  // 1 on write hit, 0 on refill
  output logic             hit_o,
  output logic             dirty_o,      // resident line needs writeback
  output logic [TAG_W-1:0] victim_tag_o  // for the writeback address
);

  // tag array, meaningless while valid is low
  logic [TAG_W-1:0]     tag_q [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;

  logic [TAG_W-1:0] cur_tag;
  logic             cur_valid;

  // status bits, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_write_i) begin
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= set_dirty_i;  // write hit marks, refill cleans
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write_i) begin
      tag_q[index_i] <= tag_i;  // same tag again on a write hit
    end
  end

  // combinational lookup
  assign cur_tag   = tag_q[index_i];
  assign cur_valid = valid_q[index_i];

  assign hit_o        = cur_valid && (cur_tag == tag_i);
  assign dirty_o      = cur_valid && dirty_q[index_i];
  assign victim_tag_o = cur_tag;

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
  parameter int NUM_LINES = 128
) (
  input  logic              clk,
  input  logic              rst,
  // cpu port
  input  logic              req_valid_i,
  input  cpu_req_t          req_i,
  output logic              done_o,
  output logic [WORD_W-1:0] rdata_o,
  // memory read port
  output logic              rd_valid_o,
  output mem_rd_req_t       rd_req_o,
  input  logic              rd_beat_i,
  input  logic [WORD_W-1:0] rd_data_i,
  // memory write port
  output logic              wr_valid_o,
  output mem_wr_req_t       wr_req_o,
  output logic [WORD_W-1:0] wr_data_o,
  input  logic              wr_beat_i
);

  localparam int IDX_W      = $clog2(NUM_LINES);
  localparam int TAG_W      = ADDR_W - IDX_W - OFFSET_W;
  localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);

  // address fields of the cpu request
  logic [IDX_W-1:0]      index;
  logic [TAG_W-1:0]      tag;
  logic [WORD_IDX_W-1:0] cpu_word;

  logic                  hit;
  logic                  dirty;
  logic [TAG_W-1:0]      victim_tag;
  logic                  tag_write;
  logic                  set_dirty;
  logic                  data_wen;
  logic [WORD_IDX_W-1:0] data_word;
  logic [WORD_W-1:0]     data_wdata;
  logic [MASK_W-1:0]     data_wmask;
  logic [WORD_W-1:0]     hit_word;
  logic [WORD_W-1:0]     line_word;

  assign tag      = req_i.addr[ADDR_W-1 -: TAG_W];
  assign index    = req_i.addr[OFFSET_W +: IDX_W];
  assign cpu_word = req_i.addr[OFFSET_W-1 -: WORD_IDX_W];

  dcache_ctrl #(
    .NUM_LINES (NUM_LINES)
  ) u_dcache_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .done_o       (done_o),
    .rdata_o      (rdata_o),
    .rd_valid_o   (rd_valid_o),
    .rd_req_o     (rd_req_o),
    .rd_beat_i    (rd_beat_i),
    .rd_data_i    (rd_data_i),
    .wr_valid_o   (wr_valid_o),
    .wr_req_o     (wr_req_o),
    .wr_data_o    (wr_data_o),
    .wr_beat_i    (wr_beat_i),
    .hit_i        (hit),
    .dirty_i      (dirty),
    .victim_tag_i (victim_tag),
    .tag_write_o  (tag_write),
    .set_dirty_o  (set_dirty),
    .hit_word_i   (hit_word),
    .line_word_i  (line_word),
    .data_wen_o   (data_wen),
    .data_word_o  (data_word),
    .data_wdata_o (data_wdata),
    .data_wmask_o (data_wmask)
  );

  dcache_tag_store #(
    .NUM_LINES (NUM_LINES)
  ) u_dcache_tag_store (
    .clk          (clk),
    .rst          (rst),
    .index_i      (index),
    .tag_i        (tag),
    .tag_write_i  (tag_write),
    .set_dirty_i  (set_dirty),
    .hit_o        (hit),
    .dirty_o      (dirty),
    .victim_tag_o (victim_tag)
  );

  dcache_data_store #(
    .NUM_LINES (NUM_LINES)
  ) u_dcache_data_store (
    .clk       (clk),
    .index_i   (index),
    .word_i    (cpu_word),   // cpu read word
    .wr_word_i (data_word),  // write and writeback word
    .wen_i     (data_wen),
    .wdata_i   (data_wdata),
    .wmask_i   (data_wmask),
    .rdata_o   (hit_word),
    .wb_data_o (line_word)
  );

endmodule

//--- run.sh
#!/bin/sh
# build the dcache testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_dcache -f tb.f; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vtb_dcache); then
  echo "$out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

//--- tb.f
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_checker.sv
verif/tb_dcache.sv

//--- verif/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker import dcache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  cpu_req_t    req_i,
  input  logic        done_i,
  input  logic [31:0] rdata_i,
  input  logic        rd_valid_i,
  input  mem_rd_req_t rd_req_i,
  input  logic        wr_valid_i,
  input  mem_wr_req_t wr_req_i,
  input  logic [31:0] exp_rdata_i,    // table value for the current request
  input  logic [3:0]  exp_bursts_i,   // read bursts, write bursts
  input  logic [31:0] exp_wb_addr_i,
  output int          err_cnt_o,
  output int          check_cnt_o
);

  int          errors     = 0;
  int          checks     = 0;
  logic        rst_q      = 1'b0;
  logic        rd_valid_q = 1'b0;
  logic        wr_valid_q = 1'b0;
  logic [1:0]  n_rd       = '0;  // bursts seen for this request
  logic [1:0]  n_wr       = '0;
  logic [31:0] line_addr;

  assign err_cnt_o   = errors;
  assign check_cnt_o = checks;
  assign line_addr   = req_i.addr & 32'hffff_ffc0;  // 64 byte line boundary

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      if (rst_q) begin  // reset seen on an earlier edge
        compare("done/rd_valid/wr_valid in reset", 64'({done_i, rd_valid_i, wr_valid_i}), 64'h0);
      end
      n_rd = '0;
      n_wr = '0;
    end else begin
      if (rd_valid_i && !rd_valid_q) begin  // new read burst
        n_rd = n_rd + 2'd1;
        if (req_i.addr[UNCACHED_BIT]) begin
          compare("uncached read request", 64'(rd_req_i), 64'({req_i.addr, 8'd0}));
        end else begin
          compare("refill request", 64'(rd_req_i), 64'({line_addr, 8'(BURST_LEN)}));
        end
      end
      if (wr_valid_i && !wr_valid_q) begin  // new write burst
        n_wr = n_wr + 2'd1;
        if (req_i.addr[UNCACHED_BIT]) begin
          compare("uncached write request", 64'(wr_req_i), 64'({req_i.addr, req_i.mask, 8'd0}));
        end else begin
          compare("writeback request", 64'(wr_req_i),
                  64'({exp_wb_addr_i, 4'hf, 8'(BURST_LEN)}));
        end
      end
      if (done_i) begin
        if (!req_i.write) begin
          compare("read data", 64'(rdata_i), 64'(exp_rdata_i));
        end
        compare("burst count", 64'({n_rd, n_wr}), 64'(exp_bursts_i));
        n_rd = '0;
        n_wr = '0;
      end
    end
    rst_q      = rst;
    rd_valid_q = rd_valid_i;
    wr_valid_q = wr_valid_i;
  end

endmodule

//--- verif/dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties import dcache_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        done_i,
  input logic        rd_valid_i,
  input logic        rd_beat_i,
  input mem_rd_req_t rd_req_i,
  input logic        wr_valid_i,
  input logic        wr_beat_i,
  input mem_wr_req_t wr_req_i
);

  logic [7:0] rd_n;  // beats taken in the open read burst
  logic [7:0] wr_n;
  logic       rd_last;
  logic       wr_last;

  // final beat of the burst taken this cycle
  assign rd_last = rd_beat_i && (rd_n == rd_req_i.len);
  assign wr_last = wr_beat_i && (wr_n == wr_req_i.len);

  // own beat counts, cleared between bursts
  always @(posedge clk) begin
    if (rst || !rd_valid_i || rd_last) begin
      rd_n <= '0;
    end else if (rd_beat_i) begin
      rd_n <= rd_n + 8'd1;
    end
  end

  always @(posedge clk) begin
    if (rst || !wr_valid_i || wr_last) begin
      wr_n <= '0;
    end else if (wr_beat_i) begin
      wr_n <= wr_n + 8'd1;
    end
  end

  a_one_port: assert property (@(posedge clk) disable iff (rst) !(rd_valid_i && wr_valid_i))
    else $error("rd_valid_o and wr_valid_o high together");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
    else $error("done_o high for two cycles");

  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    rd_valid_i && !rd_last |=> rd_valid_i)
    else $error("rd_valid_o dropped before the final beat");

  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    wr_valid_i && !wr_last |=> wr_valid_i)
    else $error("wr_valid_o dropped before the final beat");

endmodule

bind dcache_ctrl dcache_properties u_dcache_properties (
  .clk        (clk),
  .rst        (rst),
  .done_i     (done_o),
  .rd_valid_i (rd_valid_o),
  .rd_beat_i  (rd_beat_i),
  .rd_req_i   (rd_req_o),
  .wr_valid_i (wr_valid_o),
  .wr_beat_i  (wr_beat_i),
  .wr_req_i   (wr_req_o)
);

//--- verif/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam int   NUM_LINES = 128;
  localparam int   NUM_TESTS = 13;
  localparam int   TIMEOUT   = NUM_TESTS * 300;  // cycles, room for stalled bursts
  localparam logic RD        = 1'b0;
  localparam logic WR        = 1'b1;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic [31:0] exp_rdata;  // reads only
    logic [1:0]  n_rd;       // read bursts expected
    logic [1:0]  n_wr;       // write bursts expected
    logic [31:0] wb_addr;    // old line going out
  } test_t;

  // lines 0x1040, 0x3040, 0x5040 and uncached 0x8000_1050 all map to index 0x41
  test_t tests [NUM_TESTS] = '{
    '{RD, 32'h0000_1048, 32'h0, 4'h0, 32'h5a5a_1048, 2'd1, 2'd0, 32'h0},  // clean miss
    '{RD, 32'h0000_107c, 32'h0, 4'h0, 32'h5a5a_107c, 2'd0, 2'd0, 32'h0},  // same line
    '{WR, 32'h0000_1048, 32'hdead_beef, 4'b0101, 32'h0, 2'd0, 2'd0, 32'h0},
    '{RD, 32'h0000_1048, 32'h0, 4'h0, 32'h5aad_10ef, 2'd0, 2'd0, 32'h0},  // merged
    '{RD, 32'h0000_3048, 32'h0, 4'h0, 32'h5a5a_3048, 2'd1, 2'd1, 32'h0000_1040},
    '{RD, 32'h0000_1048, 32'h0, 4'h0, 32'h5aad_10ef, 2'd1, 2'd0, 32'h0},  // from memory
    '{WR, 32'h8000_1050, 32'h1234_5678, 4'b1111, 32'h0, 2'd0, 2'd1, 32'h0},
    '{RD, 32'h8000_1050, 32'h0, 4'h0, 32'h1234_5678, 2'd1, 2'd0, 32'h0},
    '{RD, 32'h0000_1050, 32'h0, 4'h0, 32'h5a5a_1050, 2'd0, 2'd0, 32'h0},  // line kept
    '{WR, 32'h0000_5048, 32'hcafe_f00d, 4'b1100, 32'h0, 2'd1, 2'd0, 32'h0},  // write miss
    '{RD, 32'h0000_5048, 32'h0, 4'h0, 32'hcafe_5048, 2'd0, 2'd0, 32'h0},
    '{RD, 32'h0000_1048, 32'h0, 4'h0, 32'h5aad_10ef, 2'd1, 2'd1, 32'h0000_5040},
    '{RD, 32'h0000_5048, 32'h0, 4'h0, 32'hcafe_5048, 2'd1, 2'd0, 32'h0}
  };

  logic        clk         = 1'b0;
  logic        rst         = 1'b1;
  logic        req_valid_i = 1'b0;
  cpu_req_t    req_i       = '0;
  logic        done_o;
  logic [31:0] rdata_o;
  logic        rd_valid_o;
  mem_rd_req_t rd_req_o;
  logic        rd_beat_i   = 1'b0;
  logic [31:0] rd_data_i   = '0;
  logic        wr_valid_o;
  mem_wr_req_t wr_req_o;
  logic [31:0] wr_data_o;
  logic        wr_beat_i   = 1'b0;

  test_t       cur    = '0;            // entry being applied
  logic [31:0] lfsr   = 32'h4bf8196e;
  logic [7:0]  rd_cnt = '0;            // beats done in the current burst
  logic [7:0]  wr_cnt = '0;
  logic [31:0] mem_q [logic [31:0]];   // only words written so far
  int          cycles = 0;
  int          err_cnt;
  int          check_cnt;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] a);
    if (mem_q.exists(a)) begin
      return mem_q[a];
    end
    return a ^ 32'h5a5a_0000;  // initial content
  endfunction

  always #2 clk = ~clk;  // 4 ns period

  dcache_top #(
    .NUM_LINES (NUM_LINES)
  ) u_dcache_top (.*);

  dcache_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req_i),
    .done_i        (done_o),
    .rdata_i       (rdata_o),
    .rd_valid_i    (rd_valid_o),
    .rd_req_i      (rd_req_o),
    .wr_valid_i    (wr_valid_o),
    .wr_req_i      (wr_req_o),
    .exp_rdata_i   (cur.exp_rdata),
    .exp_bursts_i  ({cur.n_rd, cur.n_wr}),
    .exp_wb_addr_i (cur.wb_addr),
    .err_cnt_o     (err_cnt),
    .check_cnt_o   (check_cnt)
  );

  // memory drives on the falling edge, one lfsr bit per beat decision
  always @(negedge clk) begin
    lfsr      = lfsr_step(lfsr);
    rd_beat_i = lfsr[0];
    lfsr      = lfsr_step(lfsr);
    wr_beat_i = lfsr[0];
    if (rd_valid_o) begin
      rd_data_i = mem_read(rd_req_o.addr + 32'({rd_cnt, 2'b00}));  // ascending words
    end
  end

  // beats taken on the rising edge
  always @(posedge clk) begin
    logic [31:0] a;
    logic [31:0] w;
    if (rst) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      if (rd_valid_o && rd_beat_i) begin
        rd_cnt <= (rd_cnt == rd_req_o.len) ? 8'd0 : rd_cnt + 8'd1;
      end
      if (wr_valid_o && wr_beat_i) begin
        a = wr_req_o.addr + 32'({wr_cnt, 2'b00});
        w = mem_read(a);
        for (int b = 0; b < 4; b++) begin
          if (wr_req_o.mask[b]) begin
            w[b*8 +: 8] = wr_data_o[b*8 +: 8];  // byte merge
          end
        end
        mem_q[a] = w;
        wr_cnt <= (wr_cnt == wr_req_o.len) ? 8'd0 : wr_cnt + 8'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: done_o never came, run stopped after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(negedge clk);
      cur         = tests[i];
      req_i       = '{addr: cur.addr, wdata: cur.wdata, mask: cur.mask, write: cur.write};
      req_valid_i = 1'b1;
      while (!done_o) begin
        @(negedge clk);
      end
      @(negedge clk);  // done cycle over
      req_valid_i = 1'b0;
    end
    repeat (2) @(negedge clk);
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
